//--- Bender.yml
package:
  name: mpt_walker

sources:
  - include_dirs:
      - src
    files:
      - src/mpt_pkg.sv
      - src/mpt_decode_if.sv
      - src/mpt_entry_decode.sv
      - src/mpt_walk_ctrl.sv
      - src/mpt_walker_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_mpt_walker.sv

//--- files.f
+incdir+src
src/mpt_pkg.sv
src/mpt_decode_if.sv
src/mpt_entry_decode.sv
src/mpt_walk_ctrl.sv
src/mpt_walker_top.sv
sim/tb_clock_gen.sv
sim/tb_mpt_walker.sv

//--- sim/tb_clock_gen.sv
// Testbench clock source with a period of 40 and an active-low reset held for two cycles

module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // Release on a falling edge so the first request sees a clean reset
    initial begin
        rst_no = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

//--- sim/tb_mpt_walker.sv
// MPT walker testbench with a table memory model, a reference model and result checks

`include "mpt_macros.svh"

module tb_mpt_walker import mpt_pkg::*; ();

    typedef struct packed {
        logic       allow;
        logic       page_fault;
        mpt_fault_e fault;
        mpt_perm_e  perm;
        logic       quick;
    } expect_t;

    logic                   clk_i, rst_ni, req_valid_i;
    logic [`MPT_SPA_W-1:0]  spa_i, plb_spa_o;
    mpt_access_e            access_i;
    mpt_mode_e              mode_i;
    logic [`MPT_SDID_W-1:0] sdid_i, plb_sdid_o;
    logic [`MPT_PPN_W-1:0]  ppn_i;
    logic                   m_req_o, m_gnt_i, m_rvalid_i;
    logic [`MPT_XLEN-1:0]   m_addr_o, m_rdata_i;
    logic                   busy_o, done_o, allow_o, page_fault_o;
    mpt_fault_e             fault_cause_o;
    mpt_perm_e              plb_perm_o;

    // Table words by word address
    // Missing words read as zero
    logic [`MPT_XLEN-1:0]   mem [logic [`MPT_XLEN-1:0]];
    logic [`MPT_XLEN-1:0]   addr_q [$];
    expect_t                exp_r;
    logic [`MPT_SPA_W-1:0]  exp_spa;
    logic [`MPT_SDID_W-1:0] exp_sdid;
    logic                   pending = 1'b0;
    int                     wait_cnt = 0;
    integer                 seed = 32'hed44_c3b3;
    integer                 delay_seed = 32'hed44_c3b3;

    tb_clock_gen u_clk (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    mpt_walker_top u_dut (.*);

    function automatic logic [`MPT_XLEN-1:0] read_word(logic [`MPT_XLEN-1:0] a);
        return mem.exists(a) ? mem[a] : '0;
    endfunction

    // Read needs any permission, write needs the W bit, execute the X bit
    function automatic logic grants(mpt_perm_e p, mpt_access_e a);
        logic [1:0] b;
        b = p;
        if (a == ACCESS_READ) return b != 2'd0;
        if (a == ACCESS_WRITE) return b[1];
        if (a == ACCESS_EXEC) return b[0];
        return 1'b0;
    endfunction

    // Expected verdict of one request; also queues the table reads it needs
    function automatic expect_t expected_result(logic [3:0] mode, logic [`MPT_SPA_W-1:0] spa,
                                                mpt_access_e acc, logic [`MPT_PPN_W-1:0] ppn);
        expect_t               e;
        mpt_entry_u            w;
        logic [`MPT_PPN_W-1:0] a;
        logic [1:0]            p;
        logic                  judge;
        e = '{1'b0, 1'b0, FAULT_NONE, PERM_DISALLOWED, 1'b1};
        p = 2'd0;
        judge = 1'b0;
        if (mode == 4'd0) begin
            e.allow = 1'b1;
            e.perm  = PERM_RWX;
        end else if (mode != 4'd1) begin
            e.fault = FAULT_RESERVED_BITS_USED;
        end else if (spa[`MPT_SPA_W-1:`MPT_SPA46_LIMIT_W] != '0) begin
            e.fault = FAULT_NOT_VALID_ADDR;
        end else begin
            e.quick = 1'b0;
            a = ppn + spa[45:25];
            addr_q.push_back(a);
            w = read_word(a);
            if (w.l2.reserved != '0) begin
                e.fault = FAULT_RESERVED_BITS_USED;
            end else if (w.l2.l2_type <= L2_1G_RWX) begin
                if (w.l2.info != '0) begin
                    e.fault = FAULT_INVALID_L2_INFO;
                end else begin
                    case (w.l2.l2_type)
                        L2_1G_RX:  p = PERM_RX;
                        L2_1G_RW:  p = PERM_RW;
                        L2_1G_RWX: p = PERM_RWX;
                        default:   p = PERM_DISALLOWED;
                    endcase
                    judge = 1'b1;
                end
            end else if (w.l2.l2_type == L2_L1_DIR) begin
                a = w.l2.info + spa[24:16];
                addr_q.push_back(a);
                w = read_word(a);
                if (w.l1.reserved != '0) begin
                    e.fault = FAULT_RESERVED_BITS_USED;
                end else begin
                    p = w[2*spa[15:12] +: 2];
                    judge = 1'b1;
                end
            end else if (w.l2.l2_type == L2_COARSE_PAGES) begin
                if (w[43:32] != '0) begin
                    e.fault = FAULT_RESERVED_BITS_USED;
                end else begin
                    p = w[2*spa[24:21] +: 2];
                    judge = 1'b1;
                end
            end else begin
                e.fault = FAULT_UNDEFINED_L2_TYPE;
            end
        end
        if (judge && grants(mpt_perm_e'(p), acc)) begin
            e.allow = 1'b1;
            e.perm  = mpt_perm_e'(p);
        end else if (judge) begin
            e.page_fault = 1'b1;
        end
        return e;
    endfunction

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_fault(mpt_fault_e exp, mpt_fault_e act);
        if (act !== exp) begin
            $display("FAIL t=%0t fault_cause_o expected %s got %s (%0d)",
                     $time, exp.name(), act.name(), act);
            abort_run();
        end
    endtask

    task automatic check_perm(mpt_perm_e exp, mpt_perm_e act);
        if (act !== exp) begin
            $display("FAIL t=%0t plb_perm_o expected %s got %s (%0d)",
                     $time, exp.name(), act.name(), act);
            abort_run();
        end
    endtask

    task automatic check_addr(logic [`MPT_SPA_W-1:0] exp, logic [`MPT_SPA_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL t=%0t plb_spa_o expected %h got %h", $time, exp, act);
            abort_run();
        end
    endtask

    task automatic check_sdid(logic [`MPT_SDID_W-1:0] exp, logic [`MPT_SDID_W-1:0] act);
        if (act !== exp) begin
            $display("FAIL t=%0t plb_sdid_o expected %h got %h", $time, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(string name, logic [`MPT_XLEN-1:0] exp, logic [`MPT_XLEN-1:0] act);
        if (act !== exp) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    // Drives one request strobe and waits until the checker has seen its done pulse
    task automatic send_req(logic [3:0] mode, logic [`MPT_SPA_W-1:0] spa, mpt_access_e acc,
                            logic [`MPT_PPN_W-1:0] ppn, logic poke);
        int guard;
        exp_r       = expected_result(mode, spa, acc, ppn);
        exp_spa     = spa;
        exp_sdid    = $random(seed);
        mode_i      = mpt_mode_e'(mode);
        spa_i       = spa;
        access_i    = acc;
        ppn_i       = ppn;
        sdid_i      = exp_sdid;
        req_valid_i = 1'b1;
        pending     <= 1'b1;
        @(negedge clk_i);
        req_valid_i = 1'b0;
        // A second strobe while busy must be dropped
        if (poke) begin
            spa_i       = ~spa;
            req_valid_i = 1'b1;
            @(negedge clk_i);
            req_valid_i = 1'b0;
        end
        guard = 0;
        while (pending) begin
            @(negedge clk_i);
            guard++;
            if (guard > 200) begin
                $display("Timeout: the request was never completed and checked");
                abort_run();
            end
        end
    endtask

    // Memory model with random grant and read-valid delays
    initial begin
        logic [`MPT_XLEN-1:0] addr;
        m_gnt_i    = 1'b0;
        m_rvalid_i = 1'b0;
        m_rdata_i  = '0;
        forever begin
            @(negedge clk_i);
            if (m_req_o === 1'b1) begin
                repeat ($random(delay_seed) & 3) @(negedge clk_i);
                if (addr_q.size() == 0) begin
                    $display("Memory read requested where no table read was expected");
                    abort_run();
                end else begin
                    check_word("m_addr_o", addr_q.pop_front(), m_addr_o);
                    addr    = m_addr_o;
                    m_gnt_i = 1'b1;
                    @(negedge clk_i);
                    m_gnt_i = 1'b0;
                    repeat ($random(delay_seed) & 3) @(negedge clk_i);
                    m_rdata_i  = read_word(addr);
                    m_rvalid_i = 1'b1;
                    @(negedge clk_i);
                    m_rvalid_i = 1'b0;
                end
            end
        end
    end

    // Checker compares every done pulse against the reference result
    initial begin
        forever begin
            @(negedge clk_i);
            // Busy spans from the cycle after the strobe up to the done cycle
            check_flag("busy_o", pending, busy_o);
            if (pending) begin
                wait_cnt++;
            end
            if (pending && done_o === 1'b1) begin
                if (exp_r.quick && wait_cnt != 2) begin
                    $display("done_o came %0d cycles after the strobe instead of 2", wait_cnt);
                    abort_run();
                end else if (addr_q.size() != 0) begin
                    $display("Walk ended before all expected table words were read");
                    abort_run();
                end else begin
                    check_flag("allow_o", exp_r.allow, allow_o);
                    check_flag("page_fault_o", exp_r.page_fault, page_fault_o);
                    check_fault(exp_r.fault, fault_cause_o);
                    check_perm(exp_r.perm, plb_perm_o);
                    check_addr(exp_r.allow ? exp_spa : '0, plb_spa_o);
                    check_sdid(exp_r.allow ? exp_sdid : '0, plb_sdid_o);
                    pending <= 1'b0;
                    wait_cnt = 0;
                end
            end else if (pending && wait_cnt > 100) begin
                $display("Timeout: done_o never rose for the outstanding request");
                abort_run();
            end else if (done_o === 1'b1) begin
                $display("done_o pulsed with no request outstanding");
                abort_run();
            end
        end
    end

    initial begin
        logic [`MPT_SPA_W-1:0] spa;
        logic [`MPT_PPN_W-1:0] ppn, dir, key, info;
        logic [31:0]           r;
        int                    guard;
        req_valid_i = 1'b0;
        spa_i       = '0;
        access_i    = ACCESS_READ;
        mode_i      = MODE_BARE;
        sdid_i      = '0;
        ppn_i       = '0;
        guard       = 0;
        while (rst_ni !== 1'b1) begin
            @(negedge clk_i);
            guard++;
            if (guard > 10) begin
                $display("Timeout: reset was never released");
                abort_run();
            end
        end
        @(negedge clk_i);

        for (int a = 0; a < 3; a++) begin
            send_req(4'd0, 56'h12_3456_789a_b000, mpt_access_e'(a), '0, 1'b0);
        end
        send_req(4'd1, 56'd1 << 46, ACCESS_READ, '0, 1'b0);
        send_req(4'd9, '0, ACCESS_WRITE, '0, 1'b0);

        // 1G entries against every access type
        ppn = 44'h100;
        spa = 56'h1a_2b3c_5000;
        key = ppn + spa[45:25];
        for (int t = 0; t < 4; t++) begin
            mem[key] = {17'h0, t[2:0], 44'h0};
            for (int a = 0; a < 3; a++) begin
                send_req(4'd1, spa, mpt_access_e'(a), ppn, 1'b0);
            end
        end
        mem[key] = {17'h0, 3'd2, 44'h80};
        send_req(4'd1, spa, ACCESS_READ, ppn, 1'b0);
        mem[key] = {17'h4, 3'd3, 44'h0};
        send_req(4'd1, spa, ACCESS_READ, ppn, 1'b0);

        // Two-level walk through an L1 directory
        dir = 44'h2000;
        mem[key] = {17'h0, 3'd4, dir};
        mem[dir + spa[24:16]] = {32'h0, $random(seed)};
        for (int i = 0; i < 16; i++) begin
            spa[15:12] = i[3:0];
            send_req(4'd1, spa, mpt_access_e'(i % 3), ppn, i == 3);
        end
        mem[dir + spa[24:16]] = {32'h1, 32'hffff_ffff};
        send_req(4'd1, spa, ACCESS_READ, ppn, 1'b0);

        // Coarse subranges picked by the top of PN1
        mem[key] = {17'h0, 3'd5, 12'h0, $random(seed)};
        for (int i = 0; i < 16; i++) begin
            spa[24:21] = i[3:0];
            send_req(4'd1, spa, mpt_access_e'(i % 3), ppn, i == 5);
        end
        key = ppn + spa[45:25];
        mem[key] = {17'h0, 3'd5, 12'h1, 32'h0};
        send_req(4'd1, spa, ACCESS_READ, ppn, 1'b0);
        for (int t = 6; t < 8; t++) begin
            mem[key] = {17'h0, t[2:0], 44'h0};
            send_req(4'd1, spa, ACCESS_EXEC, ppn, 1'b0);
        end

        for (int i = 0; i < 60; i++) begin
            r   = $random(seed);
            spa = {$random(seed), $random(seed)};
            if (r[1:0] != 2'd0) begin
                spa[`MPT_SPA_W-1:`MPT_SPA46_LIMIT_W] = '0;
            end
            ppn  = {r[31:24], 4'h0};
            dir  = {r[23:16], 8'h0};
            key  = ppn + spa[45:25];
            info = r[7] ? {12'h0, $random(seed)} : ((r[6:4] == 3'd4) ? dir : '0);
            mem[key] = {((r[3:2] != 2'd0) ? 17'h0 : 17'h1), r[6:4], info};
            mem[info + spa[24:16]] = {(r[8] ? 32'h0 : 32'h2), $random(seed)};
            send_req((r[11:9] == 3'd0) ? 4'd0 : ((r[11:9] == 3'd1) ? 4'd12 : 4'd1),
                     spa, mpt_access_e'(r[13:12]), ppn, 1'b0);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- src/mpt_decode_if.sv
// Link between walk control and the entry decoder, carrying the entry and its verdict

`include "mpt_macros.svh"

interface mpt_decode_if import mpt_pkg::*; (
    input logic clk_i,
    input logic rst_ni
);

    // Walk control side
    mpt_entry_u            entry;
    mpt_level_e            level;
    logic [`MPT_SPA_W-1:0] spa;
    mpt_access_e           access;

    // Verdict for the current level
    logic                  descend;
    logic [`MPT_PPN_W-1:0] next_addr;
    logic                  allow;
    mpt_perm_e             perm;
    logic                  page_fault;
    mpt_fault_e            fault;

    modport ctrl (
        output entry, level, spa, access,
        input  descend, next_addr, allow, perm, page_fault, fault
    );

    modport decode (
        input  clk_i, rst_ni, entry, level, spa, access,
        output descend, next_addr, allow, perm, page_fault, fault
    );

endinterface

//--- src/mpt_entry_decode.sv
// MPT entry decoder turning one table word into a verdict for the current level

`include "mpt_macros.svh"

module mpt_entry_decode import mpt_pkg::*; (
    mpt_decode_if.decode dec_if
);

    logic [`MPT_PN0_W-1:0] pn0;
    logic [`MPT_PN1_W-1:0] pn1;
    logic [2:0]            l2_type_raw;
    logic [3:0]            coarse_idx;
    logic                  judge;
    mpt_perm_e             perm_sel;

    // READ needs any permission, WRITE needs W, EXEC needs X
    function automatic logic perm_ok(mpt_perm_e p, mpt_access_e a);
        logic ok;
        case (a)
            ACCESS_READ:  ok = (p != PERM_DISALLOWED);
            ACCESS_WRITE: ok = (p == PERM_RW) || (p == PERM_RWX);
            ACCESS_EXEC:  ok = (p == PERM_RX) || (p == PERM_RWX);
            default:      ok = 1'b0;
        endcase
        return ok;
    endfunction

    assign pn0         = dec_if.spa[`MPT_PN0_LSB +: `MPT_PN0_W];
    assign pn1         = dec_if.spa[`MPT_PN1_LSB +: `MPT_PN1_W];
    assign l2_type_raw = dec_if.entry.l2.l2_type;

    // Top bits of PN1 pick one of sixteen 2 MiB subranges
    assign coarse_idx = pn1[`MPT_PN1_W-1 -: 4];

    always_comb begin
        dec_if.descend    = 1'b0;
        dec_if.next_addr  = '0;
        dec_if.allow      = 1'b0;
        dec_if.perm       = PERM_DISALLOWED;
        dec_if.page_fault = 1'b0;
        dec_if.fault      = FAULT_NONE;
        judge             = 1'b0;
        perm_sel          = PERM_DISALLOWED;

        if (dec_if.level == LVL_L2) begin
            if (dec_if.entry.l2.reserved != '0) begin
                dec_if.fault = FAULT_RESERVED_BITS_USED;
            end else begin
                case (dec_if.entry.l2.l2_type)
                    L2_1G_DISALLOW, L2_1G_RX, L2_1G_RW, L2_1G_RWX: begin
                        if (dec_if.entry.l2.info != '0) begin
                            dec_if.fault = FAULT_INVALID_L2_INFO;
                        end else begin
                            // Low type bits match the permission encoding
                            perm_sel = mpt_perm_e'(l2_type_raw[1:0]);
                            judge    = 1'b1;
                        end
                    end
                    L2_L1_DIR: begin
                        dec_if.descend   = 1'b1;
                        dec_if.next_addr = dec_if.entry.l2.info
                                         + {{(`MPT_PPN_W-`MPT_PN1_W){1'b0}}, pn1};
                    end
                    L2_COARSE_PAGES: begin
                        if (dec_if.entry.l2.info[`MPT_PPN_W-1:32] != '0) begin
                            dec_if.fault = FAULT_RESERVED_BITS_USED;
                        end else begin
                            perm_sel = mpt_perm_e'(dec_if.entry.l2.info[{coarse_idx, 1'b0} +: 2]);
                            judge    = 1'b1;
                        end
                    end
                    default: begin
                        dec_if.fault = FAULT_UNDEFINED_L2_TYPE;
                    end
                endcase
            end
        end else begin
            if (dec_if.entry.l1.reserved != '0) begin
                dec_if.fault = FAULT_RESERVED_BITS_USED;
            end else begin
                perm_sel = mpt_perm_e'(dec_if.entry.l1.perm[pn0]);
                judge    = 1'b1;
            end
        end

        // A selected permission either grants the access or faults the page
        if (judge) begin
            if (perm_ok(perm_sel, dec_if.access)) begin
                dec_if.allow = 1'b1;
                dec_if.perm  = perm_sel;
            end else begin
                dec_if.page_fault = 1'b1;
            end
        end
    end

    // Walk control must see exactly one verdict whatever it has loaded
    a_one_verdict: assert property (
        @(posedge dec_if.clk_i) disable iff (!dec_if.rst_ni)
        $onehot({dec_if.descend, dec_if.allow, dec_if.page_fault,
                 dec_if.fault != FAULT_NONE})
    ) else $error("entry decoder gave no single verdict");

endmodule

//--- src/mpt_macros.svh
// MPT walker widths for entry words, addresses, page fields and the domain ID

`ifndef MPT_MACROS_SVH
`define MPT_MACROS_SVH

// Entry and memory read data
`define MPT_XLEN 64

// Supervisor physical address input
`define MPT_SPA_W 56

// Table page number, also the memory word address width
`define MPT_PPN_W 44

// Supervisor domain ID
`define MPT_SDID_W 6

// Address bits usable in the 46-bit mode
`define MPT_SPA46_LIMIT_W 46

// Page field positions inside the address
`define MPT_PN0_LSB 12
`define MPT_PN1_LSB 16
`define MPT_PN2_LSB 25

// Page field widths
`define MPT_PN0_W 4
`define MPT_PN1_W 9
`define MPT_PN2_W 21

`endif

//--- src/mpt_pkg.sv
// MPT walker package with protection modes, access kinds, verdict types and the entry views

`include "mpt_macros.svh"

package mpt_pkg;

    // Protection mode field of the protection register
    typedef enum logic [3:0] {
        MODE_BARE    = 4'd0,
        MODE_SMMPT46 = 4'd1
    } mpt_mode_e;

    // Kind of access being checked, value 3 never passes
    typedef enum logic [1:0] {
        ACCESS_READ  = 2'd0,
        ACCESS_WRITE = 2'd1,
        ACCESS_EXEC  = 2'd2
    } mpt_access_e;

    // Permission encoding shared by all entry formats
    typedef enum logic [1:0] {
        PERM_DISALLOWED = 2'd0,
        PERM_RX         = 2'd1,
        PERM_RW         = 2'd2,
        PERM_RWX        = 2'd3
    } mpt_perm_e;

    // Format fault causes
    typedef enum logic [2:0] {
        FAULT_NONE               = 3'd0,
        FAULT_NOT_VALID_ADDR     = 3'd1,
        FAULT_RESERVED_BITS_USED = 3'd2,
        FAULT_INVALID_L2_INFO    = 3'd3,
        FAULT_UNDEFINED_L2_TYPE  = 3'd4
    } mpt_fault_e;

    // Second-level entry types; 6 and 7 are undefined
    typedef enum logic [2:0] {
        L2_1G_DISALLOW   = 3'd0,
        L2_1G_RX         = 3'd1,
        L2_1G_RW         = 3'd2,
        L2_1G_RWX        = 3'd3,
        L2_L1_DIR        = 3'd4,
        L2_COARSE_PAGES  = 3'd5
    } mpt_l2_type_e;

    // Table level of the entry being decoded
    typedef enum logic {
        LVL_L2 = 1'b0,
        LVL_L1 = 1'b1
    } mpt_level_e;

    // Second-level view, INFO is either a page number or coarse permissions
    typedef struct packed {
        logic [`MPT_XLEN-`MPT_PPN_W-4:0] reserved;
        mpt_l2_type_e                    l2_type;
        logic [`MPT_PPN_W-1:0]           info;
    } mpt_l2_entry_t;

    // First-level view, one 2-bit permission per PN0 page
    typedef struct packed {
        logic [`MPT_XLEN-2*(1<<`MPT_PN0_W)-1:0] reserved;
        logic [(1<<`MPT_PN0_W)-1:0][1:0]        perm;
    } mpt_l1_entry_t;

    // A fetched word, read through the view of the current level
    typedef union packed {
        mpt_l2_entry_t l2;
        mpt_l1_entry_t l1;
    } mpt_entry_u;

endpackage

//--- src/mpt_walk_ctrl.sv
// MPT walk control with request capture, mode and address check, table fetch and result registers

`include "mpt_macros.svh"

module mpt_walk_ctrl import mpt_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   req_valid_i,
    input  logic [`MPT_SPA_W-1:0]  spa_i,
    input  mpt_access_e            access_i,
    input  mpt_mode_e              mode_i,
    input  logic [`MPT_SDID_W-1:0] sdid_i,
    input  logic [`MPT_PPN_W-1:0]  ppn_i,
    output logic                   m_req_o,
    output logic [`MPT_XLEN-1:0]   m_addr_o,
    input  logic                   m_gnt_i,
    input  logic                   m_rvalid_i,
    input  logic [`MPT_XLEN-1:0]   m_rdata_i,
    output logic                   busy_o,
    output logic                   done_o,
    output logic                   allow_o,
    output logic                   page_fault_o,
    output mpt_fault_e             fault_cause_o,
    output mpt_perm_e              plb_perm_o,
    output logic [`MPT_SDID_W-1:0] plb_sdid_o,
    output logic [`MPT_SPA_W-1:0]  plb_spa_o,
    mpt_decode_if.ctrl             dec_if
);

    typedef enum logic [2:0] {
        IDLE, CHECK, FETCH, WAIT_DATA, DECODE, DONE
    } walk_state_e;

    walk_state_e              state_q, state_d;
    logic [`MPT_SPA_W-1:0]    spa_q;
    mpt_access_e              access_q;
    mpt_mode_e                mode_q;
    logic [`MPT_SDID_W-1:0]   sdid_q;
    logic [`MPT_PPN_W-1:0]    ppn_q;
    mpt_level_e               level_q;
    logic [`MPT_PPN_W-1:0]    addr_q;
    mpt_entry_u               entry_q;
    logic                     allow_q;
    logic                     page_fault_q;
    mpt_fault_e               fault_q;
    mpt_perm_e                perm_q;
    logic                     addr_too_wide;
    logic [`MPT_PN2_W-1:0]    pn2;

    assign pn2           = spa_q[`MPT_PN2_LSB +: `MPT_PN2_W];
    assign addr_too_wide = |spa_q[`MPT_SPA_W-1:`MPT_SPA46_LIMIT_W];

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:      if (req_valid_i) state_d = CHECK;
            CHECK: begin
                if (mode_q == MODE_SMMPT46 && !addr_too_wide) begin
                    state_d = FETCH;
                end else begin
                    state_d = DONE;
                end
            end
            FETCH:     if (m_gnt_i) state_d = WAIT_DATA;
            WAIT_DATA: if (m_rvalid_i) state_d = DECODE;
            DECODE:    state_d = dec_if.descend ? FETCH : DONE;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q      <= IDLE;
            level_q      <= LVL_L2;
            spa_q        <= '0;
            access_q     <= ACCESS_READ;
            entry_q      <= '0;
            allow_q      <= 1'b0;
            page_fault_q <= 1'b0;
            fault_q      <= FAULT_NONE;
            perm_q       <= PERM_DISALLOWED;
        end else begin
            state_q <= state_d;
            case (state_q)
                IDLE: begin
                    if (req_valid_i) begin
                        spa_q    <= spa_i;
                        access_q <= access_i;
                        mode_q   <= mode_i;
                        sdid_q   <= sdid_i;
                        ppn_q    <= ppn_i;
                    end
                end
                CHECK: begin
                    allow_q      <= 1'b0;
                    page_fault_q <= 1'b0;
                    perm_q       <= PERM_DISALLOWED;
                    fault_q      <= FAULT_NONE;
                    case (mode_q)
                        // No domain protection at all
                        MODE_BARE: begin
                            allow_q <= 1'b1;
                            perm_q  <= PERM_RWX;
                        end
                        MODE_SMMPT46: begin
                            if (addr_too_wide) begin
                                fault_q <= FAULT_NOT_VALID_ADDR;
                            end else begin
                                addr_q  <= ppn_q + {{(`MPT_PPN_W-`MPT_PN2_W){1'b0}}, pn2};
                                level_q <= LVL_L2;
                            end
                        end
                        default: fault_q <= FAULT_RESERVED_BITS_USED;
                    endcase
                end
                WAIT_DATA: begin
                    if (m_rvalid_i) begin
                        entry_q <= m_rdata_i;
                    end
                end
                DECODE: begin
                    if (dec_if.descend) begin
                        addr_q  <= dec_if.next_addr;
                        level_q <= LVL_L1;
                    end else begin
                        allow_q      <= dec_if.allow;
                        page_fault_q <= dec_if.page_fault;
                        fault_q      <= dec_if.fault;
                        perm_q       <= dec_if.perm;
                    end
                end
                default: ;
            endcase
        end
    end

    assign dec_if.entry  = entry_q;
    assign dec_if.level  = level_q;
    assign dec_if.spa    = spa_q;
    assign dec_if.access = access_q;

    assign m_req_o  = (state_q == FETCH);
    assign m_addr_o = m_req_o ? {{(`MPT_XLEN-`MPT_PPN_W){1'b0}}, addr_q} : '0;

    assign busy_o = (state_q != IDLE);
    assign done_o = (state_q == DONE);

    // Results are only shown in the done cycle
    assign allow_o       = done_o & allow_q;
    assign page_fault_o  = done_o & page_fault_q;
    assign fault_cause_o = done_o ? fault_q : FAULT_NONE;
    assign plb_perm_o    = (done_o && allow_q) ? perm_q : PERM_DISALLOWED;
    assign plb_sdid_o    = (done_o && allow_q) ? sdid_q : '0;
    assign plb_spa_o     = (done_o && allow_q) ? spa_q : '0;

    // Request and address hold until the memory grants
    a_req_hold: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        m_req_o && !m_gnt_i |=> m_req_o && $stable(m_addr_o)
    ) else $error("memory request dropped before grant");

    // Memory returns data only for the one granted read
    a_rvalid_in_wait: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        m_rvalid_i |-> state_q == WAIT_DATA
    ) else $error("read valid outside WAIT_DATA");

endmodule

//--- src/mpt_walker_top.sv
// MPT walker top level joining walk control and the entry decoder

`include "mpt_macros.svh"

module mpt_walker_top import mpt_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   req_valid_i,
    input  logic [`MPT_SPA_W-1:0]  spa_i,
    input  mpt_access_e            access_i,
    input  mpt_mode_e              mode_i,
    input  logic [`MPT_SDID_W-1:0] sdid_i,
    input  logic [`MPT_PPN_W-1:0]  ppn_i,
    output logic                   m_req_o,
    output logic [`MPT_XLEN-1:0]   m_addr_o,
    input  logic                   m_gnt_i,
    input  logic                   m_rvalid_i,
    input  logic [`MPT_XLEN-1:0]   m_rdata_i,
    output logic                   busy_o,
    output logic                   done_o,
    output logic                   allow_o,
    output logic                   page_fault_o,
    output mpt_fault_e             fault_cause_o,
    output mpt_perm_e              plb_perm_o,
    output logic [`MPT_SDID_W-1:0] plb_sdid_o,
    output logic [`MPT_SPA_W-1:0]  plb_spa_o
);

    mpt_decode_if dec_if (
        .clk_i  (clk_i),
        .rst_ni (rst_ni)
    );

    mpt_walk_ctrl u_walk_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_valid_i   (req_valid_i),
        .spa_i         (spa_i),
        .access_i      (access_i),
        .mode_i        (mode_i),
        .sdid_i        (sdid_i),
        .ppn_i         (ppn_i),
        .m_req_o       (m_req_o),
        .m_addr_o      (m_addr_o),
        .m_gnt_i       (m_gnt_i),
        .m_rvalid_i    (m_rvalid_i),
        .m_rdata_i     (m_rdata_i),
        .busy_o        (busy_o),
        .done_o        (done_o),
        .allow_o       (allow_o),
        .page_fault_o  (page_fault_o),
        .fault_cause_o (fault_cause_o),
        .plb_perm_o    (plb_perm_o),
        .plb_sdid_o    (plb_sdid_o),
        .plb_spa_o     (plb_spa_o),
        .dec_if        (dec_if.ctrl)
    );

    // Combinational verdict for the entry held in walk control
    mpt_entry_decode u_entry_decode (
        .dec_if (dec_if.decode)
    );

endmodule
